// File: hw/rv_pkg.sv
package rv_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;
	localparam int num_regs = 32;

	// major opcodes, insn[6:0].
	typedef enum logic [6:0] {
		op_lui     = 7'b0110111,
		op_auipc   = 7'b0010111,
		op_jal     = 7'b1101111,
		op_jalr    = 7'b1100111,
		op_branch  = 7'b1100011,
		op_reg_imm = 7'b0010011,
		op_reg_reg = 7'b0110011,
		op_environ = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_lui,
		alu_auipc,
		alu_link, // pc + 4 for jal and jalr.
		alu_none
	} alu_op_e;

	// funct3 for the register-immediate and register-register groups.
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll     = 3'b001;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_sltu    = 3'b011;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_srl_sra = 3'b101;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	localparam logic [6:0] funct7_alt = 7'b0100000; // sub and sra.

	localparam logic [xlen-1:0] pc_step = 32'd4;

endpackage

// File: hw/cla_adder.sv
`timescale 1ns/10ps

module cla_adder import rv_pkg::*; (
	input  logic [xlen-1:0] a,
	input  logic [xlen-1:0] b,
	input  logic            cin,
	output logic [xlen-1:0] sum
);

	logic [xlen-1:0] g;
	logic [xlen-1:0] p;
	logic [xlen-1:0] c;    // carry into each bit.
	logic [7:0]      g4;
	logic [7:0]      p4;
	logic [7:0]      cblk; // carry into each 4-bit group.

	// carry into position n as a flat sum of products.
	function automatic logic lookahead(input logic [7:0] gv, input logic [7:0] pv,
			input logic c0, input int n);
		logic carry;
		logic term;
		carry = c0;
		for (int k = 0; k < 8; k++) begin
			if (k < n)
				carry &= pv[k];
		end
		for (int m = 0; m < 8; m++) begin
			if (m < n) begin
				term = gv[m];
				for (int k = m + 1; k < 8; k++) begin
					if (k < n)
						term &= pv[k];
				end
				carry |= term;
			end
		end
		return carry;
	endfunction

	assign g = a & b;
	assign p = a | b;

	for (genvar k = 0; k < 8; k++) begin : grp
		assign g4[k]   = lookahead({4'b0, g[k*4 +: 4]}, {4'b0, p[k*4 +: 4]}, 1'b0, 4);
		assign p4[k]   = &p[k*4 +: 4];
		assign cblk[k] = lookahead(g4, p4, cin, k);

		for (genvar i = 0; i < 4; i++) begin : bit_c
			assign c[k*4 + i] = lookahead({4'b0, g[k*4 +: 4]}, {4'b0, p[k*4 +: 4]},
				cblk[k], i);
		end
	end

	assign sum = a ^ b ^ c;

endmodule

// File: hw/insn_decoder.sv
`timescale 1ns/10ps

module insn_decoder import rv_pkg::*; (
	input  logic [xlen-1:0]       insn,
	output logic [reg_addr_w-1:0] rs1,
	output logic [reg_addr_w-1:0] rs2,
	output logic [reg_addr_w-1:0] rd,
	output logic [xlen-1:0]       imm_i,
	output logic [xlen-1:0]       imm_b,
	output logic [xlen-1:0]       imm_j,
	output logic [xlen-1:0]       imm_u,
	output logic [4:0]            shamt,
	output alu_op_e               alu_op,
	output logic                  use_imm,
	output logic                  is_branch,
	output logic                  is_jal,
	output logic                  is_jalr,
	output logic                  is_ecall,
	output logic                  writes_rd,
	output logic [2:0]            funct3
);

	opcode_e    opcode;
	logic [6:0] funct7;

	// operation for funct7 of zero.
	function automatic alu_op_e base_op(input logic [2:0] f3);
		case (f3)
			f3_add_sub: return alu_add;
			f3_sll:     return alu_sll;
			f3_slt:     return alu_slt;
			f3_sltu:    return alu_sltu;
			f3_xor:     return alu_xor;
			f3_srl_sra: return alu_srl;
			f3_or:      return alu_or;
			f3_and:     return alu_and;
			default:    return alu_none;
		endcase
	endfunction

	assign opcode = opcode_e'(insn[6:0]);
	assign rd     = insn[11:7];
	assign funct3 = insn[14:12];
	assign rs1    = insn[19:15];
	assign rs2    = insn[24:20];
	assign funct7 = insn[31:25];
	assign shamt  = insn[24:20];

	assign imm_i = {{20{insn[31]}}, insn[31:20]};
	assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
	assign imm_u = {insn[31:12], 12'b0};

	assign is_branch = (opcode == op_branch);
	assign is_jal    = (opcode == op_jal);
	assign is_jalr   = (opcode == op_jalr);
	assign is_ecall  = (opcode == op_environ) && (insn[31:7] == '0);

	always_comb begin
		alu_op  = alu_none;
		use_imm = 1'b0;
		case (opcode)
			op_lui:   alu_op = alu_lui;
			op_auipc: alu_op = alu_auipc;
			op_jal,
			op_jalr:  alu_op = alu_link;
			op_reg_imm: begin
				use_imm = 1'b1;
				// shifts carry funct7 in the upper immediate bits.
				if (funct3 == f3_sll || funct3 == f3_srl_sra) begin
					if (funct7 == '0)
						alu_op = base_op(funct3);
					else if (funct3 == f3_srl_sra && funct7 == funct7_alt)
						alu_op = alu_sra;
				end else begin
					alu_op = base_op(funct3);
				end
			end
			op_reg_reg: begin
				if (funct7 == '0)
					alu_op = base_op(funct3);
				else if (funct7 == funct7_alt && funct3 == f3_add_sub)
					alu_op = alu_sub;
				else if (funct7 == funct7_alt && funct3 == f3_srl_sra)
					alu_op = alu_sra;
			end
			default: ; // branch, ecall and undefined write nothing.
		endcase
	end

	assign writes_rd = (alu_op != alu_none) && (rd != '0);

endmodule

// File: hw/reg_file.sv
`timescale 1ns/10ps

module reg_file import rv_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [reg_addr_w-1:0] rs1,
	input  logic [reg_addr_w-1:0] rs2,
	output logic [xlen-1:0]       rs1_data,
	output logic [xlen-1:0]       rs2_data,
	input  logic                  we,
	input  logic [reg_addr_w-1:0] rd,
	input  logic [xlen-1:0]       rd_data
);

	logic [xlen-1:0] regs [num_regs];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < num_regs; i++)
				regs[i] <= '0;
		end else if (we && rd != '0) begin
			regs[rd] <= rd_data;
		end
	end

	// x0 reads as zero.
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: hw/alu.sv
`timescale 1ns/10ps

module alu import rv_pkg::*; (
	input  alu_op_e         alu_op,
	input  logic [xlen-1:0] rs1_data,
	input  logic [xlen-1:0] rs2_data,
	input  logic [xlen-1:0] imm,
	input  logic            use_imm,
	input  logic [4:0]      shamt,
	input  logic [xlen-1:0] pc,
	output logic [xlen-1:0] result
);

	logic [xlen-1:0] operand_b;
	logic [xlen-1:0] add_b;
	logic [xlen-1:0] add_sum;
	logic [4:0]      shift_amt;
	logic            sub_sel;

	assign operand_b = use_imm ? imm : rs2_data;
	assign shift_amt = use_imm ? shamt : rs2_data[4:0];

	// two's complement subtract: invert b, carry in one.
	assign sub_sel = (alu_op == alu_sub);
	assign add_b   = sub_sel ? ~operand_b : operand_b;

	cla_adder cla_i (
		.a   (rs1_data),
		.b   (add_b),
		.cin (sub_sel),
		.sum (add_sum)
	);

	always_comb begin
		case (alu_op)
			alu_add,
			alu_sub:   result = add_sum;
			alu_sll:   result = rs1_data << shift_amt;
			alu_slt:   result = {31'b0, $signed(rs1_data) < $signed(operand_b)};
			alu_sltu:  result = {31'b0, rs1_data < operand_b};
			alu_xor:   result = rs1_data ^ operand_b;
			alu_srl:   result = rs1_data >> shift_amt;
			alu_sra:   result = $signed(rs1_data) >>> shift_amt; // sign fill.
			alu_or:    result = rs1_data | operand_b;
			alu_and:   result = rs1_data & operand_b;
			alu_lui:   result = imm;
			alu_auipc: result = pc + imm;
			alu_link:  result = pc + pc_step;
			default:   result = '0;
		endcase
	end

endmodule

// File: hw/branch_unit.sv
`timescale 1ns/10ps

module branch_unit import rv_pkg::*; (
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] rs1_data,
	input  logic [xlen-1:0] rs2_data,
	input  logic [xlen-1:0] imm_b,
	input  logic [xlen-1:0] imm_j,
	input  logic [xlen-1:0] imm_i,
	input  logic [2:0]      funct3,
	input  logic            is_branch,
	input  logic            is_jal,
	input  logic            is_jalr,
	output logic [xlen-1:0] next_pc
);

	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	logic            taken;
	logic [xlen-1:0] jalr_sum;

	always_comb begin
		case (funct3)
			f3_beq:  taken = (rs1_data == rs2_data);
			f3_bne:  taken = (rs1_data != rs2_data);
			f3_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
			f3_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
			f3_bltu: taken = (rs1_data < rs2_data);
			f3_bgeu: taken = (rs1_data >= rs2_data);
			default: taken = 1'b0; // reserved encodings fall through.
		endcase
	end

	assign jalr_sum = rs1_data + imm_i;

	always_comb begin
		if (is_jal)
			next_pc = pc + imm_j;
		else if (is_jalr)
			next_pc = {jalr_sum[xlen-1:1], 1'b0};
		else if (is_branch && taken)
			next_pc = pc + imm_b;
		else
			next_pc = pc + pc_step;
	end

endmodule

// File: hw/rv_core.sv
`timescale 1ns/10ps

module rv_core import rv_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [xlen-1:0]       insn,
	output logic [xlen-1:0]       pc,
	output logic                  halt,
	output logic                  retire_we,
	output logic [reg_addr_w-1:0] retire_rd,
	output logic [xlen-1:0]       retire_data
);

	logic [reg_addr_w-1:0] rs1;
	logic [reg_addr_w-1:0] rs2;
	logic [reg_addr_w-1:0] rd;
	logic [xlen-1:0]       imm_i;
	logic [xlen-1:0]       imm_b;
	logic [xlen-1:0]       imm_j;
	logic [xlen-1:0]       imm_u;
	logic [xlen-1:0]       alu_imm;
	logic [4:0]            shamt;
	alu_op_e               alu_op;
	logic                  use_imm;
	logic                  is_branch;
	logic                  is_jal;
	logic                  is_jalr;
	logic                  is_ecall;
	logic                  writes_rd;
	logic [2:0]            funct3;
	logic [xlen-1:0]       rs1_data;
	logic [xlen-1:0]       rs2_data;
	logic [xlen-1:0]       result;
	logic [xlen-1:0]       next_pc;

	insn_decoder insn_decoder_i (
		.insn      (insn),
		.rs1       (rs1),
		.rs2       (rs2),
		.rd        (rd),
		.imm_i     (imm_i),
		.imm_b     (imm_b),
		.imm_j     (imm_j),
		.imm_u     (imm_u),
		.shamt     (shamt),
		.alu_op    (alu_op),
		.use_imm   (use_imm),
		.is_branch (is_branch),
		.is_jal    (is_jal),
		.is_jalr   (is_jalr),
		.is_ecall  (is_ecall),
		.writes_rd (writes_rd),
		.funct3    (funct3)
	);

	// no register write while held in reset.
	assign retire_we   = writes_rd & ~rst;
	assign retire_rd   = rd;
	assign retire_data = result;

	reg_file reg_file_i (
		.clk      (clk),
		.rst      (rst),
		.rs1      (rs1),
		.rs2      (rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.we       (retire_we),
		.rd       (rd),
		.rd_data  (result)
	);

	assign alu_imm = (alu_op == alu_lui || alu_op == alu_auipc) ? imm_u : imm_i;

	alu alu_i (
		.alu_op   (alu_op),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.imm      (alu_imm),
		.use_imm  (use_imm),
		.shamt    (shamt),
		.pc       (pc),
		.result   (result)
	);

	branch_unit branch_unit_i (
		.pc        (pc),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.imm_b     (imm_b),
		.imm_j     (imm_j),
		.imm_i     (imm_i),
		.funct3    (funct3),
		.is_branch (is_branch),
		.is_jal    (is_jal),
		.is_jalr   (is_jalr),
		.next_pc   (next_pc)
	);

	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else
			pc <= next_pc;
	end

	assign halt = is_ecall; // testbench stops the run.

endmodule

// File: verif/tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;

	localparam int num_rows = 41;
	localparam int max_cycles = 4 * num_rows + 20;
	localparam logic [5:0] last_row = 6'(num_rows - 1);
	localparam logic [31:0] ecall_word = 32'h0000_0073;

	logic        clk;
	logic        rst;
	logic [31:0] insn;
	logic [31:0] pc;
	logic        halt;
	logic        retire_we;
	logic [4:0]  retire_rd;
	logic [31:0] retire_data;
	logic        in_range;

	// program table, one row per word from address 0.
	string       row_name [64];
	logic [31:0] row_insn [64];
	logic        row_we [64];
	logic [4:0]  row_rd [64];
	logic [31:0] row_data [64];
	logic [31:0] row_next [64];
	logic        row_visit [64]; // low where control flow jumps over the word.
	logic        row_stop [64];
	logic        visited [64];

	int row_count = 0;
	int pass_count = 0;
	int fail_count = 0;
	int cycles = 0;

	rv_core rv_core_i (
		.clk         (clk),
		.rst         (rst),
		.insn        (insn),
		.pc          (pc),
		.halt        (halt),
		.retire_we   (retire_we),
		.retire_rd   (retire_rd),
		.retire_data (retire_data)
	);

	// instruction memory answers in the same cycle.
	assign in_range = (pc[31:8] == 24'h0) && (pc[1:0] == 2'b00) && (pc[7:2] <= last_row);
	assign insn     = (in_range === 1'b1) ? row_insn[pc[7:2]] : 32'h0;

	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > max_cycles) begin
			$display("timeout: the core did not reach ecall within %0d cycles", max_cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] imm_op(input int f3, input int rd, input int rs1,
			input int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
	endfunction

	function automatic logic [31:0] reg_op(input int f7, input int f3, input int rd,
			input int rs1, input int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] upper_op(input logic [6:0] opc, input int rd, input int imm);
		return {imm[19:0], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] branch_op(input int f3, input int rs1, input int rs2,
			input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jal_op(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic logic [31:0] jalr_op(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b1100111};
	endfunction

	task automatic add_row(input string name, input logic [31:0] word, input int rd,
			input logic [31:0] data, input logic [31:0] next_pc, input logic visit);
		row_name[row_count]  = name;
		row_insn[row_count]  = word;
		row_we[row_count]    = (rd != 0); // x0 is never written.
		row_rd[row_count]    = rd[4:0];
		row_data[row_count]  = data;
		row_next[row_count]  = next_pc;
		row_visit[row_count] = visit;
		row_stop[row_count]  = (word == ecall_word);
		visited[row_count]   = 1'b0;
		row_count++;
	endtask

	task automatic build_program();
		add_row("addi x1 5", imm_op(0, 1, 0, 5), 1, 32'h0000_0005, 32'h04, 1'b1);
		add_row("lui x2", upper_op(7'b0110111, 2, 'h10000), 2, 32'h1000_0000, 32'h08, 1'b1);
		add_row("addi borrow chain", imm_op(0, 2, 2, -1), 2, 32'h0FFF_FFFF, 32'h0C, 1'b1);
		add_row("addi x3 1", imm_op(0, 3, 0, 1), 3, 32'h0000_0001, 32'h10, 1'b1);
		add_row("add carry all groups", reg_op(0, 0, 4, 2, 3), 4, 32'h1000_0000, 32'h14, 1'b1);
		add_row("sub wraps", reg_op('h20, 0, 5, 1, 4), 5, 32'hF000_0005, 32'h18, 1'b1);
		add_row("auipc", upper_op(7'b0010111, 6, 'h12345), 6, 32'h1234_5018, 32'h1C, 1'b1);
		add_row("sub negative", reg_op('h20, 0, 7, 3, 1), 7, 32'hFFFF_FFFC, 32'h20, 1'b1);
		add_row("xori", imm_op(4, 8, 1, 'hF0), 8, 32'h0000_00F5, 32'h24, 1'b1);
		add_row("or", reg_op(0, 6, 9, 1, 4), 9, 32'h1000_0005, 32'h28, 1'b1);
		add_row("andi", imm_op(7, 10, 2, 'hF0), 10, 32'h0000_00F0, 32'h2C, 1'b1);
		add_row("and", reg_op(0, 7, 11, 5, 2), 11, 32'h0000_0005, 32'h30, 1'b1);
		add_row("ori sign extended", imm_op(6, 13, 0, -1), 13, 32'hFFFF_FFFF, 32'h34, 1'b1);
		add_row("slli", imm_op(1, 14, 1, 4), 14, 32'h0000_0050, 32'h38, 1'b1);
		add_row("srli", imm_op(5, 15, 5, 4), 15, 32'h0F00_0000, 32'h3C, 1'b1);
		add_row("srai sign fill", imm_op(5, 16, 5, 'h404), 16, 32'hFF00_0000, 32'h40, 1'b1);
		add_row("sll", reg_op(0, 1, 17, 3, 1), 17, 32'h0000_0020, 32'h44, 1'b1);
		add_row("srl zero fill", reg_op(0, 5, 18, 7, 1), 18, 32'h07FF_FFFF, 32'h48, 1'b1);
		add_row("sra sign fill", reg_op('h20, 5, 19, 7, 3), 19, 32'hFFFF_FFFE, 32'h4C, 1'b1);
		add_row("slt signed", reg_op(0, 2, 20, 7, 1), 20, 32'h0000_0001, 32'h50, 1'b1);
		add_row("sltu unsigned", reg_op(0, 3, 21, 7, 1), 21, 32'h0000_0000, 32'h54, 1'b1);
		add_row("slti", imm_op(2, 22, 7, -3), 22, 32'h0000_0001, 32'h58, 1'b1);
		add_row("sltiu", imm_op(3, 23, 1, -1), 23, 32'h0000_0001, 32'h5C, 1'b1);
		add_row("beq not taken", branch_op(0, 1, 3, 8), 0, 32'h0, 32'h60, 1'b1);
		add_row("bne taken", branch_op(1, 1, 3, 8), 0, 32'h0, 32'h68, 1'b1);
		add_row("skipped by bne", imm_op(0, 31, 0, 1), 31, 32'h1, 32'h0, 1'b0);
		add_row("blt taken", branch_op(4, 7, 1, 8), 0, 32'h0, 32'h70, 1'b1);
		add_row("skipped by blt", imm_op(0, 31, 0, 1), 31, 32'h1, 32'h0, 1'b0);
		add_row("bge not taken", branch_op(5, 7, 1, 8), 0, 32'h0, 32'h74, 1'b1);
		add_row("bltu not taken", branch_op(6, 7, 1, 8), 0, 32'h0, 32'h78, 1'b1);
		add_row("bgeu taken", branch_op(7, 7, 1, 8), 0, 32'h0, 32'h80, 1'b1);
		add_row("skipped by bgeu", imm_op(0, 31, 0, 1), 31, 32'h1, 32'h0, 1'b0);
		add_row("jal link", jal_op(24, 8), 24, 32'h0000_0084, 32'h88, 1'b1);
		add_row("skipped by jal", imm_op(0, 31, 0, 1), 31, 32'h1, 32'h0, 1'b0);
		add_row("addi jalr base", imm_op(0, 25, 0, 'h92), 25, 32'h0000_0092, 32'h8C, 1'b1);
		add_row("jalr clears bit 0", jalr_op(26, 25, 3), 26, 32'h0000_0090, 32'h94, 1'b1);
		add_row("skipped by jalr", imm_op(0, 31, 0, 1), 31, 32'h1, 32'h0, 1'b0);
		add_row("jal x0", jal_op(0, 8), 0, 32'h0, 32'h9C, 1'b1);
		add_row("skipped by jal x0", imm_op(0, 31, 0, 1), 31, 32'h1, 32'h0, 1'b0);
		add_row("addi x0", imm_op(0, 0, 0, 7), 0, 32'h0, 32'hA0, 1'b1);
		add_row("ecall", ecall_word, 0, 32'h0, 32'h0, 1'b1);
	endtask

	task automatic report_mismatch(input string name, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		$display("mismatch %s %s: expected 0x%08h actual 0x%08h", name, what, expected, actual);
	endtask

	task automatic finish_test(input string name, input logic ok);
		if (ok) begin
			pass_count++;
			$display("ok   %s", name);
		end else begin
			fail_count++;
			$display("fail %s", name);
		end
	endtask

	initial begin
		logic [5:0] idx;
		logic       ok;
		logic       done;

		rst = 1'b1;
		build_program();
		if (row_count != num_rows) begin
			$display("program table holds %0d rows instead of %0d", row_count, num_rows);
			fail_count++;
		end

		// two cycles of reset, row 0 is already on insn.
		@(posedge clk);
		@(negedge clk);
		ok = 1'b1;
		if (pc !== 32'h0) begin
			report_mismatch("reset", "pc", 32'h0, pc);
			ok = 1'b0;
		end
		if (retire_we !== 1'b0) begin
			report_mismatch("reset", "retire_we", 32'h0, {31'b0, retire_we});
			ok = 1'b0;
		end
		if (halt !== 1'b0) begin
			report_mismatch("reset", "halt", 32'h0, {31'b0, halt});
			ok = 1'b0;
		end
		finish_test("reset", ok);
		@(posedge clk);
		#2 rst = 1'b0;

		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (in_range !== 1'b1) begin
				$display("pc 0x%08h points outside the program table", pc);
				fail_count++;
				done = 1'b1;
			end else begin
				idx = pc[7:2];
				visited[idx] = 1'b1;
				ok = 1'b1;
				if (halt !== row_stop[idx]) begin
					report_mismatch(row_name[idx], "halt", {31'b0, row_stop[idx]}, {31'b0, halt});
					ok = 1'b0;
				end
				if (retire_we !== row_we[idx]) begin
					report_mismatch(row_name[idx], "retire_we", {31'b0, row_we[idx]},
						{31'b0, retire_we});
					ok = 1'b0;
				end
				if (row_we[idx] && retire_rd !== row_rd[idx]) begin
					report_mismatch(row_name[idx], "retire_rd", {27'b0, row_rd[idx]},
						{27'b0, retire_rd});
					ok = 1'b0;
				end
				if (row_we[idx] && retire_data !== row_data[idx]) begin
					report_mismatch(row_name[idx], "retire_data", row_data[idx], retire_data);
					ok = 1'b0;
				end
				if (row_stop[idx] || halt === 1'b1) begin
					done = 1'b1; // halt ends the program.
				end else begin
					@(posedge clk);
					#2;
					if (pc !== row_next[idx]) begin
						report_mismatch(row_name[idx], "next pc", row_next[idx], pc);
						ok = 1'b0;
					end
				end
				finish_test(row_name[idx], ok);
			end
		end

		for (int i = 0; i < num_rows; i++) begin
			if (visited[i] !== row_visit[i]) begin
				if (row_visit[i])
					$display("row %0d (%s) was never fetched", i, row_name[i]);
				else
					$display("row %0d (%s) was fetched but should be jumped over", i, row_name[i]);
				fail_count++;
			end
		end

		$display("tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: files.f
hw/rv_pkg.sv
hw/cla_adder.sv
hw/insn_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/branch_unit.sv
hw/rv_core.sv
verif/tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_rv_core -f files.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_rv_core)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qxF '*** PASSED ***'; then
	exit 0
fi
exit 1
